//--- build.f
hdl/cpu_pkg.sv
hdl/inst_decoder.sv
hdl/operand_fwd.sv
hdl/id_exe_reg.sv
hdl/id_stage.sv
sim/tb_clk_gen.sv
sim/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_id_stage -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_id_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- sim/tb_id_stage.sv
`default_nettype none

module tb_id_stage;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 3;
    localparam int N_VEC      = 2000;
    localparam int N_KINDS    = 34;
    localparam int WATCHDOG_T = (N_VEC + RST_CYCLES + 8) * CLK_PERIOD;

    // operand and write-back shape of an instruction
    typedef enum logic [2:0] {
        C_NONE, C_REG, C_SHAMT, C_IMM_S, C_IMM_Z, C_LUI, C_LOAD, C_STORE
    } iclass_e;

    typedef struct packed {
        logic [5:0]        op;
        logic [5:0]        fn;
        cpu_pkg::aluop_e   aluop;
        cpu_pkg::alutype_e alutype;
        iclass_e           cls;
    } kind_t;

    typedef struct packed {
        logic [2*cpu_pkg::REG_ADDR_W-1:0] ra;
        logic [1:0]                       rreg;
        logic                             stall;
        cpu_pkg::ctrl_t                   ctrl;
        cpu_pkg::word_t                   src1;
        cpu_pkg::word_t                   src2;
        cpu_pkg::word_t                   din;
    } expect_t;

    logic                                         cpu_clk;
    logic                                         arst_n;
    cpu_pkg::word_t                               inst_i;
    cpu_pkg::word_t [cpu_pkg::NUM_SRC-1:0]        rd_i;
    cpu_pkg::bypass_t                             exe_byp_i;
    cpu_pkg::bypass_t                             mem_byp_i;
    cpu_pkg::reg_addr_t [cpu_pkg::NUM_SRC-1:0]    ra_o;
    logic [cpu_pkg::NUM_SRC-1:0]                  rreg_o;
    logic                                         stall_o;
    cpu_pkg::ctrl_t                               ctrl_o;
    cpu_pkg::word_t                               src1_o;
    cpu_pkg::word_t                               src2_o;
    cpu_pkg::word_t                               din_o;

    logic [31:0] lfsr_q = 32'hbdd6;
    expect_t     exp_q = '0;
    event        checked;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk (
        .cpu_clk_o (cpu_clk),
        .arst_n_o  (arst_n)
    );

    id_stage u_dut (
        .cpu_clk   (cpu_clk),
        .arst_n_i  (arst_n),
        .inst_i    (inst_i),
        .rd_i      (rd_i),
        .exe_byp_i (exe_byp_i),
        .mem_byp_i (mem_byp_i),
        .ra_o      (ra_o),
        .rreg_o    (rreg_o),
        .stall_o   (stall_o),
        .ctrl_o    (ctrl_o),
        .src1_o    (src1_o),
        .src2_o    (src2_o),
        .din_o     (din_o)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // mips encodings with the last two outside the decoded set
    function automatic kind_t kind_info(input int k);
        kind_t d;
        case (k)
            0:  d = '{6'h00, 6'h20, cpu_pkg::ALUOP_ADD,  cpu_pkg::ALU_ARITH, C_REG};
            1:  d = '{6'h00, 6'h21, cpu_pkg::ALUOP_ADDU, cpu_pkg::ALU_ARITH, C_REG};
            2:  d = '{6'h00, 6'h22, cpu_pkg::ALUOP_SUB,  cpu_pkg::ALU_ARITH, C_REG};
            3:  d = '{6'h00, 6'h23, cpu_pkg::ALUOP_SUBU, cpu_pkg::ALU_ARITH, C_REG};
            4:  d = '{6'h00, 6'h24, cpu_pkg::ALUOP_AND,  cpu_pkg::ALU_LOGIC, C_REG};
            5:  d = '{6'h00, 6'h25, cpu_pkg::ALUOP_OR,   cpu_pkg::ALU_LOGIC, C_REG};
            6:  d = '{6'h00, 6'h26, cpu_pkg::ALUOP_XOR,  cpu_pkg::ALU_LOGIC, C_REG};
            7:  d = '{6'h00, 6'h27, cpu_pkg::ALUOP_NOR,  cpu_pkg::ALU_LOGIC, C_REG};
            8:  d = '{6'h00, 6'h2a, cpu_pkg::ALUOP_SLT,  cpu_pkg::ALU_ARITH, C_REG};
            9:  d = '{6'h00, 6'h2b, cpu_pkg::ALUOP_SLTU, cpu_pkg::ALU_ARITH, C_REG};
            10: d = '{6'h00, 6'h00, cpu_pkg::ALUOP_SLL,  cpu_pkg::ALU_SHIFT, C_SHAMT};
            11: d = '{6'h00, 6'h02, cpu_pkg::ALUOP_SRL,  cpu_pkg::ALU_SHIFT, C_SHAMT};
            12: d = '{6'h00, 6'h03, cpu_pkg::ALUOP_SRA,  cpu_pkg::ALU_SHIFT, C_SHAMT};
            13: d = '{6'h00, 6'h04, cpu_pkg::ALUOP_SLL,  cpu_pkg::ALU_SHIFT, C_REG};
            14: d = '{6'h00, 6'h06, cpu_pkg::ALUOP_SRL,  cpu_pkg::ALU_SHIFT, C_REG};
            15: d = '{6'h00, 6'h07, cpu_pkg::ALUOP_SRA,  cpu_pkg::ALU_SHIFT, C_REG};
            16: d = '{6'h08, 6'h00, cpu_pkg::ALUOP_ADD,  cpu_pkg::ALU_ARITH, C_IMM_S};
            17: d = '{6'h09, 6'h00, cpu_pkg::ALUOP_ADDU, cpu_pkg::ALU_ARITH, C_IMM_S};
            18: d = '{6'h0a, 6'h00, cpu_pkg::ALUOP_SLT,  cpu_pkg::ALU_ARITH, C_IMM_S};
            19: d = '{6'h0b, 6'h00, cpu_pkg::ALUOP_SLTU, cpu_pkg::ALU_ARITH, C_IMM_S};
            20: d = '{6'h0c, 6'h00, cpu_pkg::ALUOP_AND,  cpu_pkg::ALU_LOGIC, C_IMM_Z};
            21: d = '{6'h0d, 6'h00, cpu_pkg::ALUOP_OR,   cpu_pkg::ALU_LOGIC, C_IMM_Z};
            22: d = '{6'h0e, 6'h00, cpu_pkg::ALUOP_XOR,  cpu_pkg::ALU_LOGIC, C_IMM_Z};
            23: d = '{6'h0f, 6'h00, cpu_pkg::ALUOP_LUI,  cpu_pkg::ALU_LOGIC, C_LUI};
            24: d = '{6'h20, 6'h00, cpu_pkg::ALUOP_LB,   cpu_pkg::ALU_ARITH, C_LOAD};
            25: d = '{6'h21, 6'h00, cpu_pkg::ALUOP_LH,   cpu_pkg::ALU_ARITH, C_LOAD};
            26: d = '{6'h23, 6'h00, cpu_pkg::ALUOP_LW,   cpu_pkg::ALU_ARITH, C_LOAD};
            27: d = '{6'h24, 6'h00, cpu_pkg::ALUOP_LBU,  cpu_pkg::ALU_ARITH, C_LOAD};
            28: d = '{6'h25, 6'h00, cpu_pkg::ALUOP_LHU,  cpu_pkg::ALU_ARITH, C_LOAD};
            29: d = '{6'h28, 6'h00, cpu_pkg::ALUOP_SB,   cpu_pkg::ALU_ARITH, C_STORE};
            30: d = '{6'h29, 6'h00, cpu_pkg::ALUOP_SH,   cpu_pkg::ALU_ARITH, C_STORE};
            31: d = '{6'h2b, 6'h00, cpu_pkg::ALUOP_SW,   cpu_pkg::ALU_ARITH, C_STORE};
            32: d = '{6'h00, 6'h18, cpu_pkg::ALUOP_NOP,  cpu_pkg::ALU_NOP,   C_NONE};
            default: d = '{6'h3f, 6'h00, cpu_pkg::ALUOP_NOP, cpu_pkg::ALU_NOP, C_NONE};
        endcase
        return d;
    endfunction

    function automatic cpu_pkg::bypass_t rand_bypass();
        cpu_pkg::bypass_t b;
        b.wreg = (rand_bits(1) != 32'd0);
        b.wa   = 5'(rand_bits(3));
        b.wd   = rand_bits(32);
        // load in flight about one time in four
        b.mreg = (rand_bits(2) == 32'd3);
        return b;
    endfunction

    // returns {hazard, value} with execute before memory before register file
    function automatic logic [32:0] pick_bypass(input logic rreg, input cpu_pkg::reg_addr_t ra,
            input cpu_pkg::word_t rdata, input cpu_pkg::bypass_t exe,
            input cpu_pkg::bypass_t mem);
        if (!rreg) begin
            return 33'd0;
        end
        if (exe.wreg && exe.wa == ra) begin
            return {exe.mreg, exe.wd};
        end
        if (mem.wreg && mem.wa == ra) begin
            return {mem.mreg, mem.wd};
        end
        return {1'b0, rdata};
    endfunction

    function automatic expect_t ref_model(input kind_t ki, input cpu_pkg::word_t ins,
            input cpu_pkg::word_t [1:0] rdata, input cpu_pkg::bypass_t exe,
            input cpu_pkg::bypass_t mem);
        expect_t        e;
        logic [32:0]    f0;
        logic [32:0]    f1;
        logic [4:0]     rs;
        logic [4:0]     rt;
        logic [15:0]    imm;
        cpu_pkg::word_t imm_x;
        rs = ins[25:21];
        rt = ins[20:16];
        imm = ins[15:0];
        e = '0;
        e.ra = {rt, rs};
        e.rreg[0] = ki.cls inside {C_REG, C_IMM_S, C_IMM_Z, C_LOAD, C_STORE};
        e.rreg[1] = ki.cls inside {C_REG, C_SHAMT, C_STORE};
        case (ki.cls)
            C_LUI:   imm_x = {imm, 16'h0000};
            C_IMM_Z: imm_x = {16'h0000, imm};
            default: imm_x = {{16{imm[15]}}, imm};
        endcase
        f0 = pick_bypass(e.rreg[0], rs, rdata[0], exe, mem);
        f1 = pick_bypass(e.rreg[1], rt, rdata[1], exe, mem);
        e.stall = f0[32] | f1[32];
        // a stall leaves the bundle as the all-zero bubble
        if (!e.stall) begin
            e.ctrl.alutype = ki.alutype;
            e.ctrl.aluop   = ki.aluop;
            e.ctrl.wreg    = !(ki.cls inside {C_NONE, C_STORE});
            e.ctrl.mreg    = (ki.cls == C_LOAD);
            if (ki.cls == C_NONE) begin
                e.ctrl.wa = '0;
            end else if (ki.cls inside {C_IMM_S, C_IMM_Z, C_LUI, C_LOAD}) begin
                e.ctrl.wa = rt;
            end else begin
                e.ctrl.wa = ins[15:11];
            end
            e.src1 = (ki.cls == C_SHAMT) ? {27'd0, ins[10:6]} : f0[31:0];
            e.src2 = (ki.cls inside {C_IMM_S, C_IMM_Z, C_LUI, C_LOAD, C_STORE}) ? imm_x
                                                                               : f1[31:0];
            e.din  = f1[31:0];
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_vector();
        kind_t          ki;
        logic [4:0]     rs;
        logic [4:0]     rt;
        logic [4:0]     rd;
        logic [4:0]     sa;
        logic [15:0]    imm;
        cpu_pkg::word_t ins;
        ki  = kind_info(int'(rand_bits(6) % N_KINDS));
        // small register range so bypass addresses collide often
        rs  = 5'(rand_bits(3));
        rt  = 5'(rand_bits(3));
        rd  = 5'(rand_bits(3));
        sa  = 5'(rand_bits(5));
        imm = 16'(rand_bits(16));
        if (ki.op == 6'h00) begin
            ins = {ki.op, rs, rt, rd, sa, ki.fn};
        end else begin
            ins = {ki.op, rs, rt, imm};
        end
        inst_i    = {ins[7:0], ins[15:8], ins[23:16], ins[31:24]};
        rd_i[0]   = rand_bits(32);
        rd_i[1]   = rand_bits(32);
        exe_byp_i = rand_bypass();
        mem_byp_i = rand_bypass();
        exp_q     = ref_model(ki, ins, rd_i, exe_byp_i, mem_byp_i);
    endtask

    initial begin : compare_proc
        // first falling edge counted is the one after the clock starts
        @(posedge cpu_clk);
        forever begin
            @(negedge cpu_clk);
            if (!arst_n) begin
                check_value("rreg_o", 64'(rreg_o), 64'd0);
                check_value("stall_o", 64'(stall_o), 64'd0);
                check_value("ctrl_o", 64'(ctrl_o), 64'd0);
                check_value("src1_o", 64'(src1_o), 64'd0);
                check_value("src2_o", 64'(src2_o), 64'd0);
                check_value("din_o", 64'(din_o), 64'd0);
            end else begin
                check_value("ra_o", 64'(ra_o), 64'(exp_q.ra));
                check_value("rreg_o", 64'(rreg_o), 64'(exp_q.rreg));
                check_value("stall_o", 64'(stall_o), 64'(exp_q.stall));
                check_value("ctrl_o", 64'(ctrl_o), 64'(exp_q.ctrl));
                check_value("src1_o", 64'(src1_o), 64'(exp_q.src1));
                check_value("src2_o", 64'(src2_o), 64'(exp_q.src2));
                check_value("din_o", 64'(din_o), 64'(exp_q.din));
            end
            -> checked;
        end
    end

    initial begin : stimulus
        inst_i    = '0;
        rd_i      = '0;
        exe_byp_i = '0;
        mem_byp_i = '0;
        for (int n = 0; n < N_VEC; n++) begin
            @(checked);
            drive_vector();
        end
        @(checked);
        $display("Done: no errors");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("timeout: stimulus did not complete within the expected time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 3
) (
    output logic cpu_clk_o,
    output logic arst_n_o
);

    initial begin
        cpu_clk_o = 1'b0;
        forever #(PERIOD / 2) cpu_clk_o = ~cpu_clk_o;
    end

    // release lands on a falling edge, away from the capture edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge cpu_clk_o);
        @(negedge cpu_clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`default_nettype none

module id_stage (
    input  wire logic                                   cpu_clk,
    input  wire logic                                   arst_n_i,
    input  wire cpu_pkg::word_t                         inst_i,
    input  wire cpu_pkg::word_t [cpu_pkg::NUM_SRC-1:0]  rd_i,
    input  wire cpu_pkg::bypass_t                       exe_byp_i,
    input  wire cpu_pkg::bypass_t                       mem_byp_i,
    output cpu_pkg::reg_addr_t [cpu_pkg::NUM_SRC-1:0]   ra_o,
    output logic [cpu_pkg::NUM_SRC-1:0]                 rreg_o,
    output logic                                        stall_o,
    output cpu_pkg::ctrl_t                              ctrl_o,
    output cpu_pkg::word_t                              src1_o,
    output cpu_pkg::word_t                              src2_o,
    output cpu_pkg::word_t                              din_o
);

    cpu_pkg::ctrl_t                                 dec_ctrl;
    cpu_pkg::operand_req_t [cpu_pkg::NUM_SRC-1:0]   dec_req;
    cpu_pkg::operand_req_t [cpu_pkg::NUM_SRC-1:0]   req;
    cpu_pkg::word_t [cpu_pkg::NUM_SRC-1:0]          fwd_val;
    cpu_pkg::word_t [cpu_pkg::NUM_SRC-1:0]          src;
    logic [cpu_pkg::NUM_SRC-1:0]                    load_hazard;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (dec_ctrl),
        .req_o  (dec_req)
    );

    // no register reads while in reset, keeps stall low too
    always_comb begin
        req = dec_req;
        for (int i = 0; i < cpu_pkg::NUM_SRC; i++) begin
            req[i].rreg = dec_req[i].rreg && arst_n_i;
        end
    end

    for (genvar i = 0; i < cpu_pkg::NUM_SRC; i++) begin : g_src
        operand_fwd u_fwd (
            .req_i         (req[i]),
            .rd_i          (rd_i[i]),
            .exe_byp_i     (exe_byp_i),
            .mem_byp_i     (mem_byp_i),
            .fwd_val_o     (fwd_val[i]),
            .src_o         (src[i]),
            .load_hazard_o (load_hazard[i])
        );

        assign ra_o[i]   = req[i].ra;
        assign rreg_o[i] = req[i].rreg;
    end

    // store data is the bypassed rt value
    id_exe_reg u_id_exe (
        .cpu_clk       (cpu_clk),
        .arst_n_i      (arst_n_i),
        .ctrl_i        (dec_ctrl),
        .src_i         (src),
        .din_i         (fwd_val[cpu_pkg::SRC_RT]),
        .load_hazard_i (load_hazard),
        .stall_o       (stall_o),
        .ctrl_o        (ctrl_o),
        .src1_o        (src1_o),
        .src2_o        (src2_o),
        .din_o         (din_o)
    );

endmodule

`default_nettype wire

//--- hdl/id_exe_reg.sv
`default_nettype none

module id_exe_reg (
    input  wire logic                                   cpu_clk,
    input  wire logic                                   arst_n_i,
    input  wire cpu_pkg::ctrl_t                         ctrl_i,
    input  wire cpu_pkg::word_t [cpu_pkg::NUM_SRC-1:0]  src_i,
    input  wire cpu_pkg::word_t                         din_i,
    input  wire logic [cpu_pkg::NUM_SRC-1:0]            load_hazard_i,
    output logic                                        stall_o,
    output cpu_pkg::ctrl_t                              ctrl_o,
    output cpu_pkg::word_t                              src1_o,
    output cpu_pkg::word_t                              src2_o,
    output cpu_pkg::word_t                              din_o
);

    cpu_pkg::ctrl_t ctrl_d;
    cpu_pkg::word_t src1_d;
    cpu_pkg::word_t src2_d;
    cpu_pkg::word_t din_d;

    assign stall_o = |load_hazard_i;

    // bubble on stall, all zero is nop with no write
    always_comb begin
        ctrl_d = ctrl_i;
        src1_d = src_i[cpu_pkg::SRC_RS];
        src2_d = src_i[cpu_pkg::SRC_RT];
        din_d  = din_i;
        if (stall_o) begin
            ctrl_d = '0;
            src1_d = '0;
            src2_d = '0;
            din_d  = '0;
        end
    end

    always_ff @(posedge cpu_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_o <= '0;
            src1_o <= '0;
            src2_o <= '0;
            din_o  <= '0;
        end else begin
            ctrl_o <= ctrl_d;
            src1_o <= src1_d;
            src2_o <= src2_d;
            din_o  <= din_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/operand_fwd.sv
`default_nettype none

module operand_fwd (
    input  wire cpu_pkg::operand_req_t  req_i,
    input  wire cpu_pkg::word_t         rd_i,
    input  wire cpu_pkg::bypass_t       exe_byp_i,
    input  wire cpu_pkg::bypass_t       mem_byp_i,
    output cpu_pkg::word_t              fwd_val_o,
    output cpu_pkg::word_t              src_o,
    output logic                        load_hazard_o
);

    logic sel_exe;
    logic sel_mem;

    // execute is younger, so it wins over memory
    assign sel_exe = req_i.rreg && exe_byp_i.wreg && (exe_byp_i.wa == req_i.ra);
    assign sel_mem = req_i.rreg && !sel_exe && mem_byp_i.wreg && (mem_byp_i.wa == req_i.ra);

    always_comb begin
        if (sel_exe) begin
            fwd_val_o = exe_byp_i.wd;
        end else if (sel_mem) begin
            fwd_val_o = mem_byp_i.wd;
        end else if (req_i.rreg) begin
            fwd_val_o = rd_i;
        end else begin
            fwd_val_o = '0;
        end
    end

    assign src_o = req_i.ovr ? req_i.ovr_val : fwd_val_o;

    // load data not back yet from that stage
    assign load_hazard_o = (sel_exe && exe_byp_i.mreg) || (sel_mem && mem_byp_i.mreg);

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  wire cpu_pkg::word_t                             inst_i,
    output cpu_pkg::ctrl_t                                  ctrl_o,
    output cpu_pkg::operand_req_t [cpu_pkg::NUM_SRC-1:0]    req_o
);

    cpu_pkg::word_t     inst;
    cpu_pkg::opcode_e   op;
    cpu_pkg::funct_e    fn;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    cpu_pkg::reg_addr_t rd;
    logic [4:0]         sa;
    logic [15:0]        imm;
    cpu_pkg::word_t     imm_ext;
    cpu_pkg::aluop_e    aluop;
    cpu_pkg::alutype_e  alutype;
    logic               valid;
    logic               is_rtype;
    logic               is_imm_alu;
    logic               is_load;
    logic               is_store;
    logic               shift_sa;
    logic               imm_sel;

    // fetch delivers the word little end first
    assign inst = {inst_i[7:0], inst_i[15:8], inst_i[23:16], inst_i[31:24]};

    assign op  = cpu_pkg::opcode_e'(inst[31:26]);
    assign fn  = cpu_pkg::funct_e'(inst[5:0]);
    assign rs  = inst[25:21];
    assign rt  = inst[20:16];
    assign rd  = inst[15:11];
    assign sa  = inst[10:6];
    assign imm = inst[15:0];

    always_comb begin
        case (op)
            cpu_pkg::OP_SPECIAL: begin
                case (fn)
                    cpu_pkg::FN_SLL:  aluop = cpu_pkg::ALUOP_SLL;
                    cpu_pkg::FN_SRL:  aluop = cpu_pkg::ALUOP_SRL;
                    cpu_pkg::FN_SRA:  aluop = cpu_pkg::ALUOP_SRA;
                    cpu_pkg::FN_SLLV: aluop = cpu_pkg::ALUOP_SLL;
                    cpu_pkg::FN_SRLV: aluop = cpu_pkg::ALUOP_SRL;
                    cpu_pkg::FN_SRAV: aluop = cpu_pkg::ALUOP_SRA;
                    cpu_pkg::FN_ADD:  aluop = cpu_pkg::ALUOP_ADD;
                    cpu_pkg::FN_ADDU: aluop = cpu_pkg::ALUOP_ADDU;
                    cpu_pkg::FN_SUB:  aluop = cpu_pkg::ALUOP_SUB;
                    cpu_pkg::FN_SUBU: aluop = cpu_pkg::ALUOP_SUBU;
                    cpu_pkg::FN_AND:  aluop = cpu_pkg::ALUOP_AND;
                    cpu_pkg::FN_OR:   aluop = cpu_pkg::ALUOP_OR;
                    cpu_pkg::FN_XOR:  aluop = cpu_pkg::ALUOP_XOR;
                    cpu_pkg::FN_NOR:  aluop = cpu_pkg::ALUOP_NOR;
                    cpu_pkg::FN_SLT:  aluop = cpu_pkg::ALUOP_SLT;
                    cpu_pkg::FN_SLTU: aluop = cpu_pkg::ALUOP_SLTU;
                    default:          aluop = cpu_pkg::ALUOP_NOP;
                endcase
            end
            cpu_pkg::OP_ADDI:  aluop = cpu_pkg::ALUOP_ADD;
            cpu_pkg::OP_ADDIU: aluop = cpu_pkg::ALUOP_ADDU;
            cpu_pkg::OP_SLTI:  aluop = cpu_pkg::ALUOP_SLT;
            cpu_pkg::OP_SLTIU: aluop = cpu_pkg::ALUOP_SLTU;
            cpu_pkg::OP_ANDI:  aluop = cpu_pkg::ALUOP_AND;
            cpu_pkg::OP_ORI:   aluop = cpu_pkg::ALUOP_OR;
            cpu_pkg::OP_XORI:  aluop = cpu_pkg::ALUOP_XOR;
            cpu_pkg::OP_LUI:   aluop = cpu_pkg::ALUOP_LUI;
            cpu_pkg::OP_LB:    aluop = cpu_pkg::ALUOP_LB;
            cpu_pkg::OP_LH:    aluop = cpu_pkg::ALUOP_LH;
            cpu_pkg::OP_LW:    aluop = cpu_pkg::ALUOP_LW;
            cpu_pkg::OP_LBU:   aluop = cpu_pkg::ALUOP_LBU;
            cpu_pkg::OP_LHU:   aluop = cpu_pkg::ALUOP_LHU;
            cpu_pkg::OP_SB:    aluop = cpu_pkg::ALUOP_SB;
            cpu_pkg::OP_SH:    aluop = cpu_pkg::ALUOP_SH;
            cpu_pkg::OP_SW:    aluop = cpu_pkg::ALUOP_SW;
            default:           aluop = cpu_pkg::ALUOP_NOP;
        endcase
    end

    // result class follows the operation
    always_comb begin
        case (aluop)
            cpu_pkg::ALUOP_NOP: alutype = cpu_pkg::ALU_NOP;
            cpu_pkg::ALUOP_SLL,
            cpu_pkg::ALUOP_SRL,
            cpu_pkg::ALUOP_SRA: alutype = cpu_pkg::ALU_SHIFT;
            cpu_pkg::ALUOP_AND,
            cpu_pkg::ALUOP_OR,
            cpu_pkg::ALUOP_XOR,
            cpu_pkg::ALUOP_NOR,
            cpu_pkg::ALUOP_LUI: alutype = cpu_pkg::ALU_LOGIC;
            default:            alutype = cpu_pkg::ALU_ARITH;
        endcase
    end

    assign valid      = (aluop != cpu_pkg::ALUOP_NOP);
    assign is_rtype   = (op == cpu_pkg::OP_SPECIAL) && valid;
    assign is_imm_alu = op inside {cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI,
                                   cpu_pkg::OP_SLTIU, cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI,
                                   cpu_pkg::OP_XORI, cpu_pkg::OP_LUI};
    assign is_load    = op inside {cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
                                   cpu_pkg::OP_LBU, cpu_pkg::OP_LHU};
    assign is_store   = op inside {cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW};
    assign shift_sa   = is_rtype && (fn inside {cpu_pkg::FN_SLL, cpu_pkg::FN_SRL, cpu_pkg::FN_SRA});
    assign imm_sel    = is_imm_alu || is_load || is_store;

    // logical immediates are zero-extended
    always_comb begin
        if (op == cpu_pkg::OP_LUI) begin
            imm_ext = {imm, 16'h0000};
        end else if (op inside {cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_XORI}) begin
            imm_ext = {16'h0000, imm};
        end else begin
            imm_ext = {{16{imm[15]}}, imm};
        end
    end

    always_comb begin
        ctrl_o.alutype = alutype;
        ctrl_o.aluop   = aluop;
        ctrl_o.wreg    = is_rtype || is_imm_alu || is_load;
        ctrl_o.mreg    = is_load;
        if (!valid) begin
            ctrl_o.wa = '0;
        end else if (is_imm_alu || is_load) begin
            ctrl_o.wa = rt;
        end else begin
            ctrl_o.wa = rd;
        end
    end

    always_comb begin
        // fixed shifts take sa in place of rs
        req_o[cpu_pkg::SRC_RS].rreg    = (is_rtype && !shift_sa) || is_load || is_store
                                         || (is_imm_alu && op != cpu_pkg::OP_LUI);
        req_o[cpu_pkg::SRC_RS].ra      = rs;
        req_o[cpu_pkg::SRC_RS].ovr     = shift_sa;
        req_o[cpu_pkg::SRC_RS].ovr_val = cpu_pkg::word_t'(sa);
        // stores still read rt for the store data
        req_o[cpu_pkg::SRC_RT].rreg    = is_rtype || is_store;
        req_o[cpu_pkg::SRC_RT].ra      = rt;
        req_o[cpu_pkg::SRC_RT].ovr     = imm_sel;
        req_o[cpu_pkg::SRC_RT].ovr_val = imm_ext;
    end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    // source operand slots, rs first
    localparam int NUM_SRC = 2;
    localparam int SRC_RS  = 0;
    localparam int SRC_RT  = 1;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // function field of the special opcode, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [2:0] {
        ALU_NOP   = 3'b000,
        ALU_ARITH = 3'b001,
        ALU_LOGIC = 3'b010,
        ALU_MOVE  = 3'b011,
        ALU_SHIFT = 3'b100
    } alutype_e;

    // immediate forms share the code of their register form
    typedef enum logic [7:0] {
        ALUOP_NOP  = 8'h00,
        ALUOP_LUI  = 8'h05,
        ALUOP_SLL  = 8'h11,
        ALUOP_SRL  = 8'h12,
        ALUOP_SRA  = 8'h13,
        ALUOP_ADD  = 8'h18,
        ALUOP_ADDU = 8'h19,
        ALUOP_SUB  = 8'h1A,
        ALUOP_SUBU = 8'h1B,
        ALUOP_AND  = 8'h1C,
        ALUOP_OR   = 8'h1D,
        ALUOP_XOR  = 8'h1E,
        ALUOP_NOR  = 8'h1F,
        ALUOP_SLT  = 8'h26,
        ALUOP_SLTU = 8'h27,
        ALUOP_LB   = 8'h90,
        ALUOP_LH   = 8'h91,
        ALUOP_LW   = 8'h92,
        ALUOP_LBU  = 8'h94,
        ALUOP_LHU  = 8'h95,
        ALUOP_SB   = 8'h98,
        ALUOP_SH   = 8'h99,
        ALUOP_SW   = 8'h9A
    } aluop_e;

    // write port of a later stage, seen from decode
    typedef struct packed {
        logic      wreg;
        reg_addr_t wa;
        word_t     wd;
        logic      mreg;
    } bypass_t;

    typedef struct packed {
        alutype_e  alutype;
        aluop_e    aluop;
        logic      wreg;
        reg_addr_t wa;
        logic      mreg;
    } ctrl_t;

    typedef struct packed {
        logic      rreg;
        reg_addr_t ra;
        logic      ovr;
        word_t     ovr_val;
    } operand_req_t;

endpackage

`default_nettype wire
